//--- src/spi_pkg.sv
package spi_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  addr_t;
    typedef logic [15:0] tranlen_t;   // frame carries tranlen+1 bytes

    // mode of one chip select
    typedef struct packed {
        logic       cpol;    // sck idle level
        logic       cpha;    // 1: sample on trailing edge
        logic       rev;     // lsb first
        logic       rsvd0;
        logic [3:0] pm;      // half period is 2*(pm+1) clocks
        logic [7:0] rsvd1;
        logic [3:0] csbef;   // half periods from cs low to first char
        logic [3:0] csaft;   // half periods from last char to cs high
        logic [7:0] rsvd2;
    } cs_mode_t;

    localparam addr_t ADDR_SPMODE  = 8'h00;
    localparam addr_t ADDR_SPIE    = 8'h04;
    localparam addr_t ADDR_SPCOM   = 8'h08;
    localparam addr_t ADDR_SPITF   = 8'h0C;
    localparam addr_t ADDR_SPIRF   = 8'h10;
    localparam addr_t ADDR_CSMODE0 = 8'h20;   // csmode n at +4n

    localparam int SPMODE_EN   = 31;
    localparam int SPCOM_CS_LO = 30;   // cs index in 31:30

    localparam int SPIE_BUSY  = 31;
    localparam int SPIE_RNE   = 30;
    localparam int SPIE_TNF_N = 29;    // set when tx fifo is full

    localparam cs_mode_t CSMODE_DEF = '0;

    // bits of a mode register that hold fields
    localparam word_t CSMODE_MASK = 32'hEF00_FF00;

endpackage

//--- src/spi_cfg_if.sv
`timescale 1ns/1ps

interface spi_cfg_if
    import spi_pkg::*;
();

    logic       enable;        // SPMODE enable
    logic [1:0] cs_idx;
    tranlen_t   tranlen;
    cs_mode_t   mode;          // mode of the selected chip select
    logic       frame_start;   // one cycle pulse
    logic       busy;

    modport regs (
        output enable, cs_idx, tranlen, mode, frame_start,
        input  busy
    );

    modport frame (
        input  enable, cs_idx, tranlen, mode, frame_start,
        output busy
    );

endinterface

//--- src/spi_axil_slave.sv
`timescale 1ns/1ps

module spi_axil_slave
    import spi_pkg::*;
(
    input  logic       S_SYSCLK,
    input  logic       S_RESETN,
    input  addr_t      s_awaddr,
    input  logic       s_awvalid,
    output logic       s_awready,
    input  word_t      s_wdata,
    input  logic [3:0] s_wstrb,
    input  logic       s_wvalid,
    output logic       s_wready,
    output logic       s_bvalid,
    output logic [1:0] s_bresp,
    input  logic       s_bready,
    input  addr_t      s_araddr,
    input  logic       s_arvalid,
    output logic       s_arready,
    output word_t      s_rdata,
    output logic [1:0] s_rresp,
    output logic       s_rvalid,
    input  logic       s_rready,
    output logic       wr_en,
    output addr_t      wr_addr,
    output word_t      wr_data,
    output logic [3:0] wr_strb,
    output logic       rd_en,
    output addr_t      rd_addr,
    input  word_t      rd_data
);

    logic wr_ready;    // awready and wready pulse together
    logic wr_accept;
    logic rd_accept;

    // address and data both present, nothing outstanding
    assign wr_accept = s_awvalid & s_wvalid & ~wr_ready & ~s_bvalid;
    assign rd_accept = s_arvalid & ~s_arready & ~s_rvalid;

    assign s_awready = wr_ready;
    assign s_wready  = wr_ready;
    assign s_bresp   = 2'b00;    // OKAY
    assign s_rresp   = 2'b00;

    assign wr_en = wr_ready & s_awvalid & s_wvalid;
    assign rd_en = s_arready & s_arvalid;

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            wr_ready  <= 1'b0;
            s_bvalid  <= 1'b0;
            s_arready <= 1'b0;
            s_rvalid  <= 1'b0;
        end else begin
            wr_ready  <= wr_accept;
            s_arready <= rd_accept;
            if (wr_en)
                s_bvalid <= 1'b1;
            else if (s_bready)
                s_bvalid <= 1'b0;
            if (rd_en)
                s_rvalid <= 1'b1;
            else if (s_rready)
                s_rvalid <= 1'b0;
        end
    end

    // latched request and read data
    always_ff @(posedge S_SYSCLK) begin
        if (wr_accept) begin
            wr_addr <= s_awaddr;
            wr_data <= s_wdata;
            wr_strb <= s_wstrb;
        end
        if (rd_accept)
            rd_addr <= s_araddr;
        if (rd_en)
            s_rdata <= rd_data;
    end

endmodule

//--- src/spi_regs.sv
`timescale 1ns/1ps

module spi_regs
    import spi_pkg::*;
#(
    parameter int NCS = 4
) (
    input  logic       S_SYSCLK,
    input  logic       S_RESETN,
    input  logic       wr_en,
    input  addr_t      wr_addr,
    input  word_t      wr_data,
    input  logic [3:0] wr_strb,
    input  logic       rd_en,
    input  addr_t      rd_addr,
    output word_t      rd_data,
    spi_cfg_if.regs    cfg,
    output logic       tx_push,
    output word_t      tx_wdata,
    input  logic       tx_full,
    output logic       rx_pop,
    input  byte_t      rx_rdata,
    input  logic       rx_empty
);

    word_t      spmode;
    word_t      spcom;
    cs_mode_t   csmode [NCS];
    word_t      spie;
    logic [1:0] wr_cs;
    logic [1:0] rd_cs;
    logic       wr_csm;
    logic       start_ok;

    function automatic word_t merge(word_t old, word_t data, logic [3:0] strb);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    assign wr_cs  = wr_addr[3:2];
    assign rd_cs  = rd_addr[3:2];
    assign wr_csm = wr_en && wr_addr[7:4] == ADDR_CSMODE0[7:4] && int'(wr_cs) < NCS;

    // only an idle, enabled block takes a new command
    assign start_ok = wr_en && wr_addr == ADDR_SPCOM && spmode[SPMODE_EN] && !cfg.busy
                      && !cfg.frame_start && int'(wr_data[SPCOM_CS_LO +: 2]) < NCS;

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            spmode          <= '0;
            spcom           <= '0;
            cfg.frame_start <= 1'b0;
            for (int i = 0; i < NCS; i++)
                csmode[i] <= CSMODE_DEF;
        end else begin
            cfg.frame_start <= start_ok;
            if (wr_en && wr_addr == ADDR_SPMODE)
                spmode <= merge(spmode, wr_data, wr_strb);
            if (start_ok)
                spcom <= wr_data;
            if (wr_csm)
                csmode[wr_cs] <= merge(csmode[wr_cs], wr_data, wr_strb) & CSMODE_MASK;
        end
    end

    assign cfg.enable  = spmode[SPMODE_EN];
    assign cfg.cs_idx  = spcom[SPCOM_CS_LO +: 2];
    assign cfg.tranlen = spcom[15:0];
    assign cfg.mode    = csmode[spcom[SPCOM_CS_LO +: 2]];

    assign tx_push  = wr_en && wr_addr == ADDR_SPITF && !tx_full;   // dropped when full
    assign tx_wdata = wr_data;
    assign rx_pop   = rd_en && rd_addr == ADDR_SPIRF && !rx_empty;

    always_comb begin
        spie             = '0;
        spie[SPIE_BUSY]  = cfg.busy;
        spie[SPIE_RNE]   = ~rx_empty;
        spie[SPIE_TNF_N] = tx_full;
    end

    always_comb begin
        rd_data = '0;
        if (rd_addr[7:4] == ADDR_CSMODE0[7:4]) begin
            if (int'(rd_cs) < NCS)
                rd_data = csmode[rd_cs];
        end else begin
            case (rd_addr)
                ADDR_SPMODE: rd_data = spmode;
                ADDR_SPIE:   rd_data = spie;
                ADDR_SPCOM:  rd_data = spcom;
                ADDR_SPIRF:  rd_data = rx_empty ? '0 : {24'b0, rx_rdata};
                default:     rd_data = '0;
            endcase
        end
    end

endmodule

//--- src/spi_fifo.sv
`timescale 1ns/1ps

module spi_fifo #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 8
) (
    input  logic S_SYSCLK,
    input  logic S_RESETN,
    input  logic push,
    input  T     wdata,
    input  logic pop,
    output T     rdata,
    output logic full,
    output logic empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    // wraps for any depth
    function automatic logic [AW-1:0] next_ptr(logic [AW-1:0] p);
        return (int'(p) == DEPTH - 1) ? '0 : p + 1'b1;
    endfunction

    assign full    = int'(count) == DEPTH;
    assign empty   = count == '0;
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;
    assign rdata   = mem[rd_ptr];    // head shows before pop

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (do_push)
            mem[wr_ptr] <= wdata;
    end

endmodule

//--- src/spi_frame_ctrl.sv
`timescale 1ns/1ps

module spi_frame_ctrl
    import spi_pkg::*;
#(
    parameter int NCS = 4
) (
    input  logic           S_SYSCLK,
    input  logic           S_RESETN,
    spi_cfg_if.frame       cfg,
    output logic           tx_pop,
    input  word_t          tx_word,
    input  logic           tx_empty,
    output logic           rx_push,
    output byte_t          rx_byte,
    output logic           char_go,
    input  logic           char_done,
    output byte_t          tx_char,
    input  byte_t          rx_char,
    input  logic           half_tick,
    output logic [NCS-1:0] spi_sel
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CSBEF,
        ST_LOAD,
        ST_SHIFT,
        ST_CSAFT
    } state_t;

    state_t     state;
    word_t      word_q;
    logic [1:0] byte_idx;    // 0 is the msb byte
    tranlen_t   remain;      // bytes after the current one
    logic [3:0] dly;         // half periods left in a cs delay
    logic [3:0] csaft_q;
    logic       busy_q;
    logic       load_ok;

    // a fresh word is needed at byte 0, so wait for one
    assign load_ok = state == ST_LOAD && (byte_idx != 2'd0 || !tx_empty);
    assign tx_pop  = load_ok && byte_idx == 2'd0;
    assign tx_char = word_q[{~byte_idx, 3'b000} +: 8];
    assign rx_push = char_done && state == ST_SHIFT;   // fifo drops it when full
    assign rx_byte = rx_char;
    assign cfg.busy = busy_q;

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            state    <= ST_IDLE;
            busy_q   <= 1'b0;
            spi_sel  <= '1;
            char_go  <= 1'b0;
            byte_idx <= '0;
            remain   <= '0;
            dly      <= '0;
            csaft_q  <= '0;
        end else begin
            char_go <= 1'b0;
            if (!cfg.enable) begin
                state   <= ST_IDLE;   // abort
                busy_q  <= 1'b0;
                spi_sel <= '1;
            end else begin
                case (state)
                    ST_IDLE: begin
                        busy_q <= cfg.frame_start;   // falls a cycle after cs rises
                        if (cfg.frame_start) begin
                            spi_sel[cfg.cs_idx] <= 1'b0;
                            remain   <= cfg.tranlen;
                            dly      <= cfg.mode.csbef;
                            csaft_q  <= cfg.mode.csaft;
                            byte_idx <= '0;
                            state    <= ST_CSBEF;
                        end
                    end
                    ST_CSBEF: begin
                        if (dly == '0)
                            state <= ST_LOAD;
                        else if (half_tick)
                            dly <= dly - 1'b1;
                    end
                    ST_LOAD: begin
                        if (load_ok) begin
                            char_go <= 1'b1;
                            state   <= ST_SHIFT;
                        end
                    end
                    ST_SHIFT: begin
                        if (char_done) begin
                            byte_idx <= byte_idx + 1'b1;
                            if (remain == '0) begin
                                dly   <= csaft_q;
                                state <= ST_CSAFT;
                            end else begin
                                remain <= remain - 1'b1;
                                state  <= ST_LOAD;
                            end
                        end
                    end
                    ST_CSAFT: begin
                        if (dly == '0) begin
                            spi_sel <= '1;
                            state   <= ST_IDLE;
                        end else if (half_tick) begin
                            dly <= dly - 1'b1;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (tx_pop)
            word_q <= tx_word;
    end

endmodule

//--- src/spi_char_shifter.sv
`timescale 1ns/1ps

module spi_char_shifter
    import spi_pkg::*;
(
    input  logic     S_SYSCLK,
    input  logic     S_RESETN,
    input  logic     enable,
    input  cs_mode_t mode,
    input  logic     char_go,
    input  byte_t    tx_char,
    output logic     char_done,
    output byte_t    rx_char,
    output logic     half_tick,
    output logic     spi_sck,
    output logic     spi_mosi,
    input  logic     spi_miso
);

    logic [4:0] div_cnt;
    logic [4:0] div_last;    // 2*pm+1
    logic       active;
    logic [3:0] edge_cnt;    // sck edges done in this char
    byte_t      tx_q;
    logic       lead;        // next edge leaves idle level
    logic [2:0] bit_num;

    function automatic logic pick(byte_t b, logic [2:0] n, logic lsb_first);
        return lsb_first ? b[n] : b[3'd7 - n];
    endfunction

    assign div_last  = {mode.pm, 1'b1};
    assign half_tick = enable && div_cnt == div_last;
    assign lead      = ~edge_cnt[0];
    assign bit_num   = edge_cnt[3:1];

    // restart on char_go so the first edge is a full half period away
    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN)
            div_cnt <= '0;
        else if (!enable || char_go || half_tick)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            active    <= 1'b0;
            edge_cnt  <= '0;
            char_done <= 1'b0;
            spi_sck   <= 1'b0;
            spi_mosi  <= 1'b0;
        end else begin
            char_done <= 1'b0;
            if (!enable) begin
                active  <= 1'b0;
                spi_sck <= mode.cpol;
            end else if (!active) begin
                spi_sck <= mode.cpol;   // rest at cpol
                if (char_go) begin
                    active   <= 1'b1;
                    edge_cnt <= '0;
                    if (!mode.cpha)
                        spi_mosi <= pick(tx_char, 3'd0, mode.rev);   // setup before edge 1
                end
            end else if (half_tick) begin
                spi_sck  <= ~spi_sck;
                edge_cnt <= edge_cnt + 1'b1;
                // cpha 1 drives on leading edges, cpha 0 on trailing ones
                if (mode.cpha ? lead : (!lead && bit_num != 3'd7))
                    spi_mosi <= pick(tx_q, mode.cpha ? bit_num : bit_num + 3'd1, mode.rev);
                if (edge_cnt == 4'd15) begin
                    active    <= 1'b0;
                    char_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (char_go && !active)
            tx_q <= tx_char;
        if (active && half_tick && (lead ^ mode.cpha))
            rx_char <= mode.rev ? {spi_miso, rx_char[7:1]} : {rx_char[6:0], spi_miso};
    end

endmodule

//--- src/spi_master_top.sv
`timescale 1ns/1ps

module spi_master_top
    import spi_pkg::*;
#(
    parameter int NCS      = 4,
    parameter int TX_DEPTH = 8,
    parameter int RX_DEPTH = 16
) (
    input  logic           S_SYSCLK,
    input  logic           S_RESETN,
    input  addr_t          s_awaddr,
    input  logic           s_awvalid,
    output logic           s_awready,
    input  word_t          s_wdata,
    input  logic [3:0]     s_wstrb,
    input  logic           s_wvalid,
    output logic           s_wready,
    output logic           s_bvalid,
    output logic [1:0]     s_bresp,
    input  logic           s_bready,
    input  addr_t          s_araddr,
    input  logic           s_arvalid,
    output logic           s_arready,
    output word_t          s_rdata,
    output logic [1:0]     s_rresp,
    output logic           s_rvalid,
    input  logic           s_rready,
    output logic           spi_sck,
    output logic           spi_mosi,
    input  logic           spi_miso,
    output logic [NCS-1:0] spi_sel
);

    logic       wr_en;
    addr_t      wr_addr;
    word_t      wr_data;
    logic [3:0] wr_strb;
    logic       rd_en;
    addr_t      rd_addr;
    word_t      rd_data;
    logic       tx_push;
    word_t      tx_wdata;
    logic       tx_full;
    logic       tx_pop;
    word_t      tx_word;
    logic       tx_empty;
    logic       rx_push;
    byte_t      rx_byte;
    logic       rx_pop;
    byte_t      rx_rdata;
    logic       rx_empty;
    logic       char_go;
    logic       char_done;
    byte_t      tx_char;
    byte_t      rx_char;
    logic       half_tick;

    spi_cfg_if cfg ();

    spi_axil_slave u_axil (.*);

    spi_regs #(.NCS(NCS)) u_regs (.*);

    spi_fifo #(.T(word_t), .DEPTH(TX_DEPTH)) u_tx_fifo (
        .S_SYSCLK (S_SYSCLK),
        .S_RESETN (S_RESETN),
        .push     (tx_push),
        .wdata    (tx_wdata),
        .pop      (tx_pop),
        .rdata    (tx_word),
        .full     (tx_full),
        .empty    (tx_empty)
    );

    // rx full needs no flag, pushes are just dropped
    spi_fifo #(.T(byte_t), .DEPTH(RX_DEPTH)) u_rx_fifo (
        .S_SYSCLK (S_SYSCLK),
        .S_RESETN (S_RESETN),
        .push     (rx_push),
        .wdata    (rx_byte),
        .pop      (rx_pop),
        .rdata    (rx_rdata),
        .full     (),
        .empty    (rx_empty)
    );

    spi_frame_ctrl #(.NCS(NCS)) u_frame (.*);

    spi_char_shifter u_shifter (
        .enable (cfg.enable),
        .mode   (cfg.mode),
        .*
    );

endmodule

//--- bench/tb_spi_master.sv
`timescale 1ns/1ps

module tb_spi_master
    import spi_pkg::*;
();

    localparam int NCS      = 4;
    localparam int TX_DEPTH = 8;
    localparam int RX_DEPTH = 16;
    localparam int TMO      = 20000;   // clocks per wait

    logic           S_SYSCLK;
    logic           S_RESETN;
    addr_t          s_awaddr;
    logic           s_awvalid;
    logic           s_awready;
    word_t          s_wdata;
    logic [3:0]     s_wstrb;
    logic           s_wvalid;
    logic           s_wready;
    logic           s_bvalid;
    logic [1:0]     s_bresp;
    logic           s_bready;
    addr_t          s_araddr;
    logic           s_arvalid;
    logic           s_arready;
    word_t          s_rdata;
    logic [1:0]     s_rresp;
    logic           s_rvalid;
    logic           s_rready;
    logic           spi_sck;
    logic           spi_mosi;
    logic           spi_miso;
    logic [NCS-1:0] spi_sel;

    // slave model state
    cs_mode_t cur_mode;
    word_t    lfsr_s;
    byte_t    s_out;
    byte_t    s_in;
    int       dcount;
    int       scount;
    logic     seen_lead;
    byte_t    mosi_q [$];
    byte_t    miso_q [$];
    word_t    tx_model [$];   // words sitting in the tx fifo
    realtime  t_sel_fall;
    realtime  t_sel_rise;
    realtime  t_first;
    realtime  t_second;
    realtime  t_last;
    int       n_edges;

    wire sel_idle = &spi_sel;

    spi_master_top #(
        .NCS      (NCS),
        .TX_DEPTH (TX_DEPTH),
        .RX_DEPTH (RX_DEPTH)
    ) u_spi_master_top (.*);

    initial begin
        S_SYSCLK = 1'b0;
        forever #20 S_SYSCLK = ~S_SYSCLK;
    end

    function automatic word_t lfsr_step(word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // expected mosi byte k of a word, msb byte first
    function automatic byte_t ref_byte(word_t w, int k);
        return w[31 - 8*k -: 8];
    endfunction

    function automatic logic bit_at(byte_t b, int d, logic rev);
        return rev ? b[d] : b[7 - d];
    endfunction

    function automatic cs_mode_t make_mode(logic cpol, logic cpha, logic rev,
                                           logic [3:0] pm, logic [3:0] bef, logic [3:0] aft);
        cs_mode_t m;
        m       = '0;
        m.cpol  = cpol;
        m.cpha  = cpha;
        m.rev   = rev;
        m.pm    = pm;
        m.csbef = bef;
        m.csaft = aft;
        return m;
    endfunction

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(string what, word_t got, word_t exp);
        if (got !== exp)
            stop_on_error($sformatf("Error at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_byte(string what, byte_t got, byte_t exp);
        if (got !== exp)
            stop_on_error($sformatf("Error at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_sel(logic [NCS-1:0] got, logic [NCS-1:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("Error at %0t: spi_sel got %b expected %b", $time, got, exp));
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        if (got !== exp)
            stop_on_error($sformatf("Error at %0t: %s got %b expected %b", $time, what, got, exp));
    endtask

    task automatic check_resp(string what, logic [1:0] got, logic [1:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("Error at %0t: %s got %b expected %b", $time, what, got, exp));
    endtask

    task automatic check_time(string what, realtime got, realtime lo, realtime hi);
        if (got < lo || got > hi)
            stop_on_error($sformatf("Error at %0t: %s took %0t ns, allowed %0t to %0t",
                                    $time, what, got, lo, hi));
    endtask

    // one miso byte, one lfsr step per bit
    task automatic load_miso();
        for (int i = 0; i < 8; i++) begin
            s_out[i] = lfsr_s[0];
            lfsr_s   = lfsr_step(lfsr_s);
        end
    endtask

    task automatic drive_bit();
        if (cur_mode.cpha) begin
            if (dcount == 0)
                load_miso();
            spi_miso <= bit_at(s_out, dcount, cur_mode.rev);
            dcount = (dcount + 1) % 8;
        end else begin
            dcount++;
            if (dcount == 8) begin
                load_miso();
                dcount = 0;
            end
            spi_miso <= bit_at(s_out, dcount, cur_mode.rev);
        end
    endtask

    task automatic sample_bit();
        s_in = cur_mode.rev ? {spi_mosi, s_in[7:1]} : {s_in[6:0], spi_mosi};
        scount++;
        if (scount == 8) begin
            mosi_q.push_back(s_in);
            miso_q.push_back(s_out);
            scount = 0;
        end
    endtask

    always @(sel_idle) begin
        if (sel_idle === 1'b0) begin
            t_sel_fall = $realtime;
            n_edges    = 0;
            dcount     = 0;
            scount     = 0;
            seen_lead  = 1'b0;
            if (!cur_mode.cpha) begin
                load_miso();   // first bit ready before the leading edge
                spi_miso <= bit_at(s_out, 0, cur_mode.rev);
            end
        end else if (sel_idle === 1'b1) begin
            t_sel_rise = $realtime;
        end
    end

    // a move to the rest level counts only after a leading edge
    always @(spi_sck) begin
        if (sel_idle === 1'b0 && (spi_sck !== cur_mode.cpol || seen_lead)) begin
            n_edges++;
            if (n_edges == 1)
                t_first = $realtime;
            if (n_edges == 2)
                t_second = $realtime;
            t_last = $realtime;
            if (spi_sck !== cur_mode.cpol) begin
                seen_lead = 1'b1;
                if (cur_mode.cpha)
                    drive_bit();
                else
                    sample_bit();
            end else begin
                seen_lead = 1'b0;
                if (cur_mode.cpha)
                    sample_bit();
                else
                    drive_bit();
            end
        end
    end

    task automatic axi_write(addr_t a, word_t d, logic [3:0] st);
        int t;
        @(posedge S_SYSCLK);
        s_awaddr  <= a;
        s_wdata   <= d;
        s_wstrb   <= st;
        s_awvalid <= 1'b1;
        s_wvalid  <= 1'b1;
        t = 0;
        do begin
            @(posedge S_SYSCLK);
            t++;
        end while (!s_awready && t < TMO);
        if (t >= TMO)
            stop_on_error("AXI write was never accepted");
        check_bit("wready with awready", s_wready, 1'b1);
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        t = 0;
        while (!s_bvalid && t < TMO) begin
            @(posedge S_SYSCLK);
            t++;
        end
        if (t >= TMO)
            stop_on_error("AXI write response never arrived");
        check_resp("bresp", s_bresp, 2'b00);   // OKAY
    endtask

    task automatic axi_read(addr_t a, output word_t d);
        int t;
        @(posedge S_SYSCLK);
        s_araddr  <= a;
        s_arvalid <= 1'b1;
        t = 0;
        do begin
            @(posedge S_SYSCLK);
            t++;
        end while (!s_arready && t < TMO);
        if (t >= TMO)
            stop_on_error("AXI read address was never accepted");
        s_arvalid <= 1'b0;
        t = 0;
        while (!s_rvalid && t < TMO) begin
            @(posedge S_SYSCLK);
            t++;
        end
        if (t >= TMO)
            stop_on_error("AXI read data never arrived");
        check_resp("rresp", s_rresp, 2'b00);
        d = s_rdata;
    endtask

    task automatic wait_sel(logic lvl, int limit);
        int t;
        t = 0;
        while (sel_idle !== lvl && t < limit) begin
            @(posedge S_SYSCLK);
            t++;
        end
        if (sel_idle !== lvl)
            stop_on_error("chip select did not change in time");
    endtask

    // one frame, then mosi and spirf against the expected streams
    task automatic run_frame(logic [1:0] cs, tranlen_t len, cs_mode_t m);
        word_t          w [$];
        word_t          rd;
        int             n;
        logic [NCS-1:0] exp_sel;
        n        = int'(len) + 1;
        cur_mode = m;
        mosi_q.delete();
        miso_q.delete();
        for (int i = 0; i < (n + 3) / 4; i++)
            w.push_back(tx_model.pop_front());   // leftover bytes are lost
        exp_sel     = '1;
        exp_sel[cs] = 1'b0;
        axi_write(ADDR_SPCOM, {cs, 14'b0, len}, 4'hF);
        wait_sel(1'b0, TMO);
        check_sel(spi_sel, exp_sel);
        wait_sel(1'b1, TMO);
        check_bit("sck idle level", spi_sck, m.cpol);
        check_word("mosi byte count", mosi_q.size(), n);
        for (int i = 0; i < n; i++)
            check_byte("mosi byte", mosi_q[i], ref_byte(w[i / 4], i % 4));
        for (int i = 0; i < n; i++) begin
            axi_read(ADDR_SPIRF, rd);
            check_word("spirf byte", rd, {24'b0, miso_q[i]});
        end
        axi_read(ADDR_SPIRF, rd);
        check_word("spirf when empty", rd, '0);
        axi_read(ADDR_SPIE, rd);
        check_bit("spie busy after frame", rd[SPIE_BUSY], 1'b0);
    endtask

    initial begin
        cs_mode_t modes [4];
        word_t    rd;
        word_t    w;
        S_RESETN  = 1'b0;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b1;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b1;
        spi_miso  = 1'b0;
        cur_mode  = '0;
        lfsr_s    = 32'h41f2_1247;
        repeat (10) @(posedge S_SYSCLK);
        S_RESETN <= 1'b1;

        // register access
        modes[0] = make_mode(0, 0, 0, 0, 0, 0);
        modes[1] = make_mode(0, 1, 0, 0, 1, 0);
        modes[2] = make_mode(1, 0, 1, 0, 0, 1);
        modes[3] = make_mode(1, 1, 1, 0, 0, 0);
        for (int i = 0; i < 4; i++)
            axi_write(ADDR_CSMODE0 + addr_t'(4 * i), modes[i], 4'hF);
        for (int i = 0; i < 4; i++) begin
            axi_read(ADDR_CSMODE0 + addr_t'(4 * i), rd);
            check_word("csmode readback", rd, modes[i]);
        end
        axi_write(ADDR_CSMODE0 + 8'd4, 32'hFFFF_FFFF, 4'b0010);
        axi_read(ADDR_CSMODE0 + 8'd4, rd);
        check_word("csmode1 byte strobe", rd, {modes[1][31:16], 8'hFF, modes[1][7:0]});
        axi_write(ADDR_CSMODE0 + 8'd4, modes[1], 4'hF);
        axi_write(ADDR_SPMODE, 32'h8000_0000, 4'hF);
        axi_write(ADDR_SPMODE, 32'h0000_0000, 4'b0111);   // enable byte untouched
        axi_read(ADDR_SPMODE, rd);
        check_word("spmode readback", rd, 32'h8000_0000);
        for (int i = 0; i <= TX_DEPTH; i++) begin
            w = 32'hA1B2_C3D0 + 32'h0102_0304 * i;
            axi_write(ADDR_SPITF, w, 4'hF);
            if (i < TX_DEPTH)
                tx_model.push_back(w);   // last one hits a full fifo
            if (i == TX_DEPTH - 1) begin
                axi_read(ADDR_SPIE, rd);
                check_bit("spie tx full", rd[SPIE_TNF_N], 1'b1);
            end
        end

        run_frame(2'd0, 16'd7, modes[0]);   // mode 0, two words
        run_frame(2'd1, 16'd3, modes[1]);
        run_frame(2'd2, 16'd3, modes[2]);
        run_frame(2'd3, 16'd3, modes[3]);
        run_frame(2'd0, 16'd2, modes[0]);   // partial word
        run_frame(2'd0, 16'd3, modes[0]);

        // prescaler and cs delays
        modes[0] = make_mode(0, 0, 0, 3, 2, 1);
        axi_write(ADDR_CSMODE0, modes[0], 4'hF);
        run_frame(2'd0, 16'd3, modes[0]);
        check_time("sck half period", t_second - t_first, 320.0, 320.0);
        check_time("cs to first edge", t_first - t_sel_fall, 640.0, 1.0e6);
        check_time("last edge to cs", t_sel_rise - t_last, 320.0, 1.0e6);

        // abort mid frame
        modes[0] = make_mode(0, 0, 0, 15, 0, 0);
        axi_write(ADDR_CSMODE0, modes[0], 4'hF);
        cur_mode = modes[0];
        axi_write(ADDR_SPITF, 32'h5A5A_C3C3, 4'hF);
        axi_write(ADDR_SPCOM, {2'd0, 14'b0, 16'd3}, 4'hF);
        wait_sel(1'b0, TMO);
        repeat (40) @(posedge S_SYSCLK);
        axi_write(ADDR_SPMODE, 32'h0000_0000, 4'hF);
        wait_sel(1'b1, 4);   // far sooner than the frame would end
        axi_read(ADDR_SPIE, rd);
        check_bit("spie busy after abort", rd[SPIE_BUSY], 1'b0);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- flist.f
src/spi_pkg.sv
src/spi_cfg_if.sv
src/spi_axil_slave.sv
src/spi_regs.sv
src/spi_fifo.sv
src/spi_frame_ctrl.sv
src/spi_char_shifter.sv
src/spi_master_top.sv
bench/tb_spi_master.sv
